// File: bench/ctrl_chk.sv
`timescale 1ns/10ps

module ctrl_chk (
    input logic                clk_i,
    input logic                reset_i,
    input logic                is_valid_i,
    input logic                stall_i,
    input ctrl_pkg::ctrl_sig_t ctrl_i,
    input ctrl_pkg::beat_t     beat_i,
    input ctrl_pkg::beat_t     list_count_i
);

    // an empty pipeline slot never holds the pipeline back
    idle_no_stall: assert property (@(posedge clk_i) disable iff (reset_i)
        !is_valid_i |-> !stall_i)
        else $error("stall_o is high while is_valid_i is low");

    mem_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
        !(ctrl_i.mem_read && ctrl_i.mem_write))
        else $error("mem_read and mem_write are high together");

    reset_no_stall: assert property (@(posedge clk_i)
        reset_i |=> !stall_i)
        else $error("stall_o is high in the cycle after reset");

    // the finish cycle is the only one where the count reaches the list size
    beat_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
        beat_i <= list_count_i)
        else $error("beat count ran past the register list size");

endmodule

bind ctrl_top ctrl_chk u_chk (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .is_valid_i   (is_valid_i),
    .stall_i      (stall_o),
    .ctrl_i       (ctrl_o),
    .beat_i       (beat),
    .list_count_i (list_count)
);

// File: bench/ctrl_tb.sv
`timescale 1ns/10ps
`include "ctrl_config.svh"

module ctrl_tb;
    import ctrl_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 8;
    localparam int SEQ_PER_KIND = 4;
    localparam int NUM_TESTS = 3 + 3 * SEQ_PER_KIND;
    localparam int CYCLES_PER_TEST = 20;
    localparam int MAX_SEQ_CYCLES = CYCLES_PER_TEST - 2;

    logic        clk;
    logic        reset;
    logic        is_valid;
    instr_t      instr;
    ctrl_sig_t   ctrl;
    logic        stall;
    reg_addr_t   reg_addr;
    word_t       imm;
    logic [15:0] lfsr_q;
    string       test_name;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;

    ctrl_top uut (
        .clk_i      (clk),
        .reset_i    (reset),
        .is_valid_i (is_valid),
        .instr_i    (instr),
        .ctrl_o     (ctrl),
        .stall_o    (stall),
        .reg_addr_o (reg_addr),
        .imm_o      (imm)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // every test fits in CYCLES_PER_TEST cycles, so this only fires on a hang
    initial begin
        #((NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before all tests had finished");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hB400;
        return state >> 1;
    endfunction

    task automatic take_bits(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    function automatic instr_t dp_instr(input logic [3:0] op);
        return {6'b010000, op, 3'd1, 3'd2};
    endfunction

    function automatic word_t beat_offset(input multi_kind_e kind, input int n, input int k);
        case (kind)
            MULTI_STM:  return word_t'(`CTRL_BYTES_PER_REG * k);
            MULTI_PUSH: return word_t'(`CTRL_BYTES_PER_REG * (n - k));
            default:    return word_t'(`CTRL_BYTES_PER_REG * (n - 1 - k));
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("mismatch %s %s: expected %0h actual %0h", test_name, what, expected,
                     actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != errors_at_start)
            tests_failed++;
        $display("test %s done with %0d errors", test_name, errors - errors_at_start);
        // an idle slot between tests lets the sequencer restart
        is_valid = 1'b0;
        instr = '0;
        next_cycle();
    endtask

    task automatic check_alu(input instr_t word, input alu_op_e op, input alu_src_e src_1,
                             input alu_src_e src_2, input logic wr);
        instr = word;
        is_valid = 1'b1;
        #3;
        check_val("alu fields", 32'({op, src_1, src_2, wr, 1'b1}),
                  32'({ctrl.alu_op, ctrl.alu_src_1, ctrl.alu_src_2, ctrl.reg_write,
                       ctrl.update_flags}));
        check_val("stall", 32'(0), 32'(stall));
        next_cycle();
    endtask

    task automatic check_mem(input instr_t word, input logic is_load);
        instr = word;
        is_valid = 1'b1;
        #3;
        check_val("mem fields", 32'({is_load, !is_load, is_load, is_load}),
                  32'({ctrl.mem_read, ctrl.mem_write, ctrl.reg_write, ctrl.data_from_mem}));
        check_val("stall", 32'(0), 32'(stall));
        next_cycle();
    endtask

    task automatic run_multi(input multi_kind_e kind, input logic [2:0] base,
                             input logic [7:0] low_list, input logic push_lr);
        reg_addr_t order[$];
        int        n;
        int        k;
        logic      is_ldm;
        logic      fin_write;
        reg_addr_t fin_reg;
        instr_t    word;
        is_ldm = (kind == MULTI_LDM);
        case (kind)
            MULTI_STM: word = {5'b11000, base, low_list};
            MULTI_LDM: word = {5'b11001, base, low_list};
            default:   word = {7'b1011010, push_lr, low_list};
        endcase
        if (is_ldm) begin
            for (int i = `CTRL_LOW_REGS - 1; i >= 0; i--)
                if (low_list[i])
                    order.push_back(reg_addr_t'(i));
        end else begin
            for (int i = 0; i < `CTRL_LOW_REGS; i++)
                if (low_list[i])
                    order.push_back(reg_addr_t'(i));
            // the link register rides at the top of a PUSH list
            if (kind == MULTI_PUSH && push_lr)
                order.push_back(reg_addr_t'(14));
        end
        n = order.size();
        fin_reg = (kind == MULTI_PUSH) ? reg_addr_t'(`CTRL_SP_REG_NUM) : reg_addr_t'(base);
        fin_write = !(is_ldm && low_list[base]);

        instr = word;
        is_valid = 1'b1;
        k = 0;
        #3;
        while (stall && k < MAX_SEQ_CYCLES) begin
            if (k < n) begin
                check_val("beat reg_addr", 32'(order[k]), 32'(reg_addr));
                check_val("beat imm", beat_offset(kind, n, k), imm);
                check_val("beat ctrl", 32'({!is_ldm, is_ldm, is_ldm, SRC_ACC, 1'b1}),
                          32'({ctrl.mem_write, ctrl.reg_write, ctrl.data_from_mem,
                               ctrl.alu_src_2, ctrl.addr_from_ctrl}));
            end
            k++;
            next_cycle();
            #3;
        end
        assert (!stall)
        else begin
            $display("test %s: stall stayed high for %0d cycles", test_name, k);
            errors++;
        end
        check_val("stall cycles", 32'(n), 32'(k));
        check_val("finish reg_addr", 32'(fin_reg), 32'(reg_addr));
        check_val("finish imm", word_t'(`CTRL_BYTES_PER_REG * n), imm);
        check_val("finish ctrl", 32'({fin_write, 1'b0, 1'b1}),
                  32'({ctrl.reg_write, ctrl.mem_write, ctrl.addr_from_ctrl}));
        next_cycle();
    endtask

    initial begin
        logic [15:0] bits;
        logic [7:0]  list;
        logic [2:0]  base;
        reset = 1'b1;
        is_valid = 1'b0;
        instr = '0;
        lfsr_q = 16'd11177;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();
        next_cycle();

        start_test("dp_logic");
        check_alu(dp_instr(4'b0000), ALU_AND, SRC_REG, SRC_REG, 1'b1);
        check_alu(dp_instr(4'b1100), ALU_OR, SRC_REG, SRC_REG, 1'b1);
        check_alu(dp_instr(4'b0001), ALU_XOR, SRC_REG, SRC_REG, 1'b1);
        check_alu(dp_instr(4'b0010), ALU_LSL, SRC_REG, SRC_REG, 1'b1);
        check_alu(dp_instr(4'b1000), ALU_AND, SRC_REG, SRC_REG, 1'b0);
        check_alu(dp_instr(4'b1010), ALU_SUB, SRC_REG, SRC_REG, 1'b0);
        end_test();

        start_test("add_sub_mov_imm");
        check_alu({7'b0001110, 3'd5, 3'd1, 3'd2}, ALU_ADD, SRC_REG, SRC_IMM, 1'b1);
        check_alu({7'b0001111, 3'd5, 3'd1, 3'd2}, ALU_SUB, SRC_REG, SRC_IMM, 1'b1);
        check_alu({5'b00100, 3'd3, 8'h5A}, ALU_ADD, SRC_ZERO, SRC_IMM, 1'b1);
        check_alu({5'b00110, 3'd3, 8'h21}, ALU_ADD, SRC_REG, SRC_IMM, 1'b1);
        check_alu({5'b00111, 3'd3, 8'h21}, ALU_SUB, SRC_REG, SRC_IMM, 1'b1);
        check_alu({5'b00101, 3'd3, 8'h21}, ALU_SUB, SRC_REG, SRC_IMM, 1'b0);
        end_test();

        start_test("load_store");
        check_mem({5'b01101, 5'd3, 3'd1, 3'd2}, 1'b1);
        check_mem({5'b01100, 5'd3, 3'd1, 3'd2}, 1'b0);
        check_mem({7'b0101100, 3'd3, 3'd1, 3'd2}, 1'b1);
        check_mem({7'b0101000, 3'd3, 3'd1, 3'd2}, 1'b0);
        end_test();

        for (int i = 0; i < SEQ_PER_KIND; i++) begin
            start_test($sformatf("stm_%0d", i));
            take_bits(8, bits);
            list = bits[7:0];
            take_bits(3, bits);
            base = bits[2:0];
            // the last one covers the empty list
            if (i == SEQ_PER_KIND - 1)
                list = '0;
            run_multi(MULTI_STM, base, list, 1'b0);
            end_test();
        end

        for (int i = 0; i < SEQ_PER_KIND; i++) begin
            start_test($sformatf("ldm_%0d", i));
            take_bits(8, bits);
            list = bits[7:0];
            take_bits(3, bits);
            base = bits[2:0];
            // alternate so both the suppressed and the normal writeback occur
            list[base] = i[0];
            run_multi(MULTI_LDM, base, list, 1'b0);
            end_test();
        end

        for (int i = 0; i < SEQ_PER_KIND; i++) begin
            start_test($sformatf("push_%0d", i));
            take_bits(8, bits);
            list = bits[7:0];
            run_multi(MULTI_PUSH, 3'd0, list, !i[0]);
            end_test();
        end

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: hw/beat_counter.sv
`timescale 1ns/10ps

module beat_counter (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            restart_i,
    input  logic            advance_i,
    output ctrl_pkg::beat_t beat_o
);
    import ctrl_pkg::*;

    beat_t beat_q;

    // restart wins over advance so a finish cycle always leaves the count at zero
    always_ff @(posedge clk_i) begin
        if (reset_i || restart_i) begin
            beat_q <= '0;
        end else if (advance_i) begin
            beat_q <= beat_q + beat_t'(1);
        end
    end

    assign beat_o = beat_q;

endmodule

// File: hw/ctrl_config.svh
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// datapath word and the instruction / register-list half word
`define CTRL_WORD_WIDTH 32
`define CTRL_HALF_WORD 16

// register file addressing
`define CTRL_REG_ADDR_WIDTH 4
`define CTRL_LOW_REGS 8
`define CTRL_SP_REG_NUM 13

// each multi-register beat moves one 32-bit word
`define CTRL_BYTES_PER_REG 4
`define CTRL_BEAT_WIDTH 5

`endif

// File: hw/ctrl_pkg.sv
`include "ctrl_config.svh"

package ctrl_pkg;

    typedef logic [`CTRL_WORD_WIDTH-1:0] word_t;
    typedef logic [`CTRL_HALF_WORD-1:0] instr_t;
    typedef logic [`CTRL_REG_ADDR_WIDTH-1:0] reg_addr_t;
    // one bit per register, bit i set means register i is named
    typedef logic [`CTRL_HALF_WORD-1:0] reg_list_t;
    typedef logic [`CTRL_BEAT_WIDTH-1:0] beat_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_BIC,
        ALU_NOT,
        ALU_LSL,
        ALU_LSR,
        ALU_ASR,
        ALU_ROR
    } alu_op_e;

    // SRC_ACC selects the offset that the controller drives on imm_o
    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_ZERO,
        SRC_ACC
    } alu_src_e;

    typedef enum logic [1:0] {
        MULTI_NONE,
        MULTI_STM,
        MULTI_LDM,
        MULTI_PUSH
    } multi_kind_e;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_XFER
    } seq_state_e;

    typedef struct packed {
        alu_op_e  alu_op;
        alu_src_e alu_src_1;
        alu_src_e alu_src_2;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     update_flags;
        logic     data_from_mem;
        // use reg_addr_o from the controller rather than the instruction field
        logic     addr_from_ctrl;
    } ctrl_sig_t;

endpackage

// File: hw/ctrl_top.sv
`timescale 1ns/10ps

module ctrl_top (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                is_valid_i,
    input  ctrl_pkg::instr_t    instr_i,
    output ctrl_pkg::ctrl_sig_t ctrl_o,
    output logic                stall_o,
    output ctrl_pkg::reg_addr_t reg_addr_o,
    output ctrl_pkg::word_t     imm_o
);
    import ctrl_pkg::*;

    ctrl_sig_t   base_ctrl;
    multi_kind_e multi_kind;
    reg_list_t   reg_list;
    reg_addr_t   base_reg;
    logic        advance;
    logic        restart;
    logic        reverse;
    beat_t       beat;
    logic        any_left;
    reg_addr_t   next_reg;
    beat_t       list_count;
    logic        base_hit;

    instr_decoder u_decoder (
        .instr_i      (instr_i),
        .ctrl_o       (base_ctrl),
        .multi_kind_o (multi_kind),
        .reg_list_o   (reg_list),
        .base_reg_o   (base_reg)
    );

    multi_reg_fsm u_fsm (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .is_valid_i   (is_valid_i),
        .base_ctrl_i  (base_ctrl),
        .multi_kind_i (multi_kind),
        .base_reg_i   (base_reg),
        .beat_i       (beat),
        .any_left_i   (any_left),
        .next_reg_i   (next_reg),
        .list_count_i (list_count),
        .base_hit_i   (base_hit),
        .advance_o    (advance),
        .restart_o    (restart),
        .reverse_o    (reverse),
        .ctrl_o       (ctrl_o),
        .stall_o      (stall_o),
        .reg_addr_o   (reg_addr_o),
        .imm_o        (imm_o)
    );

    beat_counter u_beats (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .restart_i (restart),
        .advance_i (advance),
        .beat_o    (beat)
    );

    reg_list_tracker u_tracker (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .restart_i    (restart),
        .advance_i    (advance),
        .reverse_i    (reverse),
        .reg_list_i   (reg_list),
        .base_reg_i   (base_reg),
        .any_left_o   (any_left),
        .next_reg_o   (next_reg),
        .list_count_o (list_count),
        .base_hit_o   (base_hit)
    );

endmodule

// File: hw/instr_decoder.sv
`timescale 1ns/10ps
`include "ctrl_config.svh"

module instr_decoder (
    input  ctrl_pkg::instr_t      instr_i,
    output ctrl_pkg::ctrl_sig_t   ctrl_o,
    output ctrl_pkg::multi_kind_e multi_kind_o,
    output ctrl_pkg::reg_list_t   reg_list_o,
    output ctrl_pkg::reg_addr_t   base_reg_o
);
    import ctrl_pkg::*;

    always_comb begin
        ctrl_o.alu_op         = ALU_ADD;
        ctrl_o.alu_src_1      = SRC_REG;
        ctrl_o.alu_src_2      = SRC_REG;
        ctrl_o.reg_write      = 1'b0;
        ctrl_o.mem_read       = 1'b0;
        ctrl_o.mem_write      = 1'b0;
        ctrl_o.update_flags   = 1'b0;
        ctrl_o.data_from_mem  = 1'b0;
        ctrl_o.addr_from_ctrl = 1'b0;
        multi_kind_o          = MULTI_NONE;
        reg_list_o            = '0;
        base_reg_o            = reg_addr_t'(instr_i[10:8]);

        casez (instr_i[15:10])
            // shift by immediate, add/sub register or 3-bit immediate, 8-bit immediate ops
            6'b00????: begin
                ctrl_o.update_flags = 1'b1;
                ctrl_o.reg_write    = 1'b1;
                casez (instr_i[13:9])
                    5'b000??: begin
                        ctrl_o.alu_op    = ALU_LSL;
                        ctrl_o.alu_src_2 = SRC_IMM;
                    end
                    5'b001??: begin
                        ctrl_o.alu_op    = ALU_LSR;
                        ctrl_o.alu_src_2 = SRC_IMM;
                    end
                    5'b010??: begin
                        ctrl_o.alu_op    = ALU_ASR;
                        ctrl_o.alu_src_2 = SRC_IMM;
                    end
                    5'b01100: ctrl_o.alu_op = ALU_ADD;
                    5'b01101: ctrl_o.alu_op = ALU_SUB;
                    5'b01110, 5'b110??: begin
                        ctrl_o.alu_op    = ALU_ADD;
                        ctrl_o.alu_src_2 = SRC_IMM;
                    end
                    5'b01111, 5'b111??: begin
                        ctrl_o.alu_op    = ALU_SUB;
                        ctrl_o.alu_src_2 = SRC_IMM;
                    end
                    // move is an add of the immediate to zero
                    5'b100??: begin
                        ctrl_o.alu_src_1 = SRC_ZERO;
                        ctrl_o.alu_src_2 = SRC_IMM;
                    end
                    5'b101??: begin
                        ctrl_o.alu_op    = ALU_SUB;
                        ctrl_o.alu_src_2 = SRC_IMM;
                        ctrl_o.reg_write = 1'b0;
                    end
                    default: ;
                endcase
            end
            6'b010000: begin
                ctrl_o.update_flags = 1'b1;
                ctrl_o.reg_write    = 1'b1;
                case (instr_i[9:6])
                    4'b0000: ctrl_o.alu_op = ALU_AND;
                    4'b0001: ctrl_o.alu_op = ALU_XOR;
                    4'b0010: ctrl_o.alu_op = ALU_LSL;
                    4'b0011: ctrl_o.alu_op = ALU_LSR;
                    4'b0100: ctrl_o.alu_op = ALU_ASR;
                    4'b0111: ctrl_o.alu_op = ALU_ROR;
                    4'b1000: begin
                        ctrl_o.alu_op    = ALU_AND;
                        ctrl_o.reg_write = 1'b0;
                    end
                    // negate is zero minus the register
                    4'b1001: begin
                        ctrl_o.alu_op    = ALU_SUB;
                        ctrl_o.alu_src_1 = SRC_ZERO;
                    end
                    4'b1010: begin
                        ctrl_o.alu_op    = ALU_SUB;
                        ctrl_o.reg_write = 1'b0;
                    end
                    4'b1011: begin
                        ctrl_o.alu_op    = ALU_ADD;
                        ctrl_o.reg_write = 1'b0;
                    end
                    4'b1100: ctrl_o.alu_op = ALU_OR;
                    4'b1110: ctrl_o.alu_op = ALU_BIC;
                    4'b1111: ctrl_o.alu_op = ALU_NOT;
                    // carry ops and multiply are not supported and do nothing
                    default: begin
                        ctrl_o.update_flags = 1'b0;
                        ctrl_o.reg_write    = 1'b0;
                    end
                endcase
            end
            // register offset load and store
            // the signed loads are the 2'b11 codes with bit 11 clear
            6'b0101??: begin
                if (instr_i[11] || (instr_i[10:9] == 2'b11)) begin
                    ctrl_o.mem_read      = 1'b1;
                    ctrl_o.reg_write     = 1'b1;
                    ctrl_o.data_from_mem = 1'b1;
                end else begin
                    ctrl_o.mem_write = 1'b1;
                end
            end
            // immediate offset word, byte, halfword and SP-based load/store
            6'b011???, 6'b1000??, 6'b1001??: begin
                ctrl_o.alu_src_2 = SRC_IMM;
                if (instr_i[11]) begin
                    ctrl_o.mem_read      = 1'b1;
                    ctrl_o.reg_write     = 1'b1;
                    ctrl_o.data_from_mem = 1'b1;
                end else begin
                    ctrl_o.mem_write = 1'b1;
                end
            end
            6'b101101: begin
                // bit 9 clear is PUSH, bit 8 adds the link register
                if (!instr_i[9]) begin
                    multi_kind_o     = MULTI_PUSH;
                    reg_list_o       = reg_list_t'({instr_i[8], 6'b0,
                                                    instr_i[`CTRL_LOW_REGS-1:0]});
                    base_reg_o       = reg_addr_t'(`CTRL_SP_REG_NUM);
                    ctrl_o.alu_op    = ALU_SUB;
                    ctrl_o.alu_src_2 = SRC_ACC;
                end
            end
            6'b11000?, 6'b11001?: begin
                multi_kind_o     = instr_i[11] ? MULTI_LDM : MULTI_STM;
                reg_list_o       = reg_list_t'(instr_i[`CTRL_LOW_REGS-1:0]);
                ctrl_o.alu_src_2 = SRC_ACC;
            end
            default: ;
        endcase
    end

endmodule

// File: hw/multi_reg_fsm.sv
`timescale 1ns/10ps
`include "ctrl_config.svh"

module multi_reg_fsm (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  is_valid_i,
    input  ctrl_pkg::ctrl_sig_t   base_ctrl_i,
    input  ctrl_pkg::multi_kind_e multi_kind_i,
    input  ctrl_pkg::reg_addr_t   base_reg_i,
    input  ctrl_pkg::beat_t       beat_i,
    input  logic                  any_left_i,
    input  ctrl_pkg::reg_addr_t   next_reg_i,
    input  ctrl_pkg::beat_t       list_count_i,
    input  logic                  base_hit_i,
    output logic                  advance_o,
    output logic                  restart_o,
    output logic                  reverse_o,
    output ctrl_pkg::ctrl_sig_t   ctrl_o,
    output logic                  stall_o,
    output ctrl_pkg::reg_addr_t   reg_addr_o,
    output ctrl_pkg::word_t       imm_o
);
    import ctrl_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    logic       is_multi;
    logic       in_beat;
    logic       finish;
    logic       abandon;
    word_t      n_bytes;
    word_t      k_bytes;

    assign is_multi = (multi_kind_i != MULTI_NONE);
    assign in_beat  = is_valid_i && is_multi && any_left_i;
    assign finish   = is_valid_i && is_multi && !any_left_i;
    // the instruction was replaced while a sequence was still running
    assign abandon  = (state_q == SEQ_XFER) && !is_multi;

    assign stall_o   = in_beat;
    assign advance_o = in_beat;
    assign restart_o = !is_valid_i || finish || abandon;
    assign reverse_o = (multi_kind_i == MULTI_LDM);

    assign state_d = in_beat ? SEQ_XFER : SEQ_IDLE;

    always_ff @(posedge clk_i) begin
        if (reset_i)
            state_q <= SEQ_IDLE;
        else
            state_q <= state_d;
    end

    assign n_bytes = word_t'(list_count_i) * word_t'(`CTRL_BYTES_PER_REG);
    assign k_bytes = word_t'(beat_i) * word_t'(`CTRL_BYTES_PER_REG);

    always_comb begin
        ctrl_o     = base_ctrl_i;
        reg_addr_o = '0;
        imm_o      = '0;
        if (is_multi) begin
            ctrl_o.reg_write      = 1'b0;
            ctrl_o.mem_read       = 1'b0;
            ctrl_o.mem_write      = 1'b0;
            ctrl_o.update_flags   = 1'b0;
            ctrl_o.data_from_mem  = 1'b0;
            ctrl_o.alu_src_2      = SRC_ACC;
            ctrl_o.addr_from_ctrl = 1'b1;
            if (in_beat) begin
                reg_addr_o = next_reg_i;
                case (multi_kind_i)
                    MULTI_STM: begin
                        ctrl_o.mem_write = 1'b1;
                        imm_o            = k_bytes;
                    end
                    // PUSH stores from the bottom of the new stack frame upwards
                    MULTI_PUSH: begin
                        ctrl_o.mem_write = 1'b1;
                        imm_o            = n_bytes - k_bytes;
                    end
                    // LDM walks the list from the top register down
                    MULTI_LDM: begin
                        ctrl_o.reg_write     = 1'b1;
                        ctrl_o.data_from_mem = 1'b1;
                        imm_o = n_bytes - word_t'(`CTRL_BYTES_PER_REG) - k_bytes;
                    end
                    default: ;
                endcase
            end else begin
                // finish cycle writes the base or stack pointer back
                ctrl_o.reg_write = !((multi_kind_i == MULTI_LDM) && base_hit_i);
                reg_addr_o       = base_reg_i;
                imm_o            = n_bytes;
            end
        end
        // an empty slot must not touch the register file, memory or flags
        if (!is_valid_i) begin
            ctrl_o.reg_write    = 1'b0;
            ctrl_o.mem_read     = 1'b0;
            ctrl_o.mem_write    = 1'b0;
            ctrl_o.update_flags = 1'b0;
        end
    end

endmodule

// File: hw/reg_list_tracker.sv
`timescale 1ns/10ps
`include "ctrl_config.svh"

module reg_list_tracker (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                restart_i,
    input  logic                advance_i,
    input  logic                reverse_i,
    input  ctrl_pkg::reg_list_t reg_list_i,
    input  ctrl_pkg::reg_addr_t base_reg_i,
    output logic                any_left_o,
    output ctrl_pkg::reg_addr_t next_reg_o,
    output ctrl_pkg::beat_t     list_count_o,
    output logic                base_hit_o
);
    import ctrl_pkg::*;

    localparam reg_list_t LOW_MASK = reg_list_t'((1 << `CTRL_LOW_REGS) - 1);

    // a set bit means that register has not been transferred yet
    reg_list_t mask_q;
    reg_list_t pick_pool;
    reg_list_t pick_onehot;
    logic      hit_q;

    // reverse mode only looks at the low registers, which is all LDM can name
    assign pick_pool = reg_list_i & mask_q & (reverse_i ? LOW_MASK : '1);
    assign any_left_o = |pick_pool;

    always_comb begin
        next_reg_o = '0;
        if (reverse_i) begin
            // ascending scan so the highest set bit is the last one kept
            for (int i = 0; i < `CTRL_LOW_REGS; i++) begin
                if (pick_pool[i])
                    next_reg_o = reg_addr_t'(i);
            end
        end else begin
            for (int i = `CTRL_HALF_WORD - 1; i >= 0; i--) begin
                if (pick_pool[i])
                    next_reg_o = reg_addr_t'(i);
            end
        end
    end

    assign pick_onehot = any_left_o ? (reg_list_t'(1) << next_reg_o) : '0;

    always_comb begin
        list_count_o = '0;
        for (int i = 0; i < `CTRL_HALF_WORD; i++) begin
            list_count_o = list_count_o + beat_t'(reg_list_i[i]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || restart_i) begin
            mask_q <= '1;
            hit_q  <= 1'b0;
        end else if (advance_i) begin
            mask_q <= mask_q & ~pick_onehot;
            if (any_left_o && (next_reg_o == base_reg_i))
                hit_q <= 1'b1;
        end
    end

    assign base_hit_o = hit_q;

endmodule

// File: run.sh
#!/bin/bash
# build and run the controller testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module ctrl_tb -f sources.f -o ctrl_sim

./obj_dir/ctrl_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "run.sh: simulation reported failure"
    exit 1
fi
echo "run.sh: simulation done"

// File: sources.f
+incdir+hw
hw/ctrl_pkg.sv
hw/instr_decoder.sv
hw/beat_counter.sv
hw/reg_list_tracker.sv
hw/multi_reg_fsm.sv
hw/ctrl_top.sv
bench/ctrl_chk.sv
bench/ctrl_tb.sv
